// File: mips_exec_params.svh
`ifndef MIPS_EXEC_PARAMS_SVH
`define MIPS_EXEC_PARAMS_SVH

`define MIPS_XLEN    32
`define MIPS_REG_AW  5

`define OP_RTYPE     6'h00
`define OP_BEQ       6'h04
`define OP_BNE       6'h05
`define OP_BLEZ      6'h06
`define OP_BGTZ      6'h07
`define OP_ADDIU     6'h09
`define OP_SLTI      6'h0a
`define OP_SLTIU     6'h0b
`define OP_ANDI      6'h0c
`define OP_ORI       6'h0d
`define OP_XORI      6'h0e
`define OP_LUI       6'h0f

`define FN_SLL       6'h00
`define FN_SRL       6'h02
`define FN_SRA       6'h03
`define FN_SLLV      6'h04
`define FN_SRLV      6'h06
`define FN_SRAV      6'h07
`define FN_JR        6'h08
`define FN_MFHI      6'h10
`define FN_MFLO      6'h12
`define FN_MULT      6'h18
`define FN_MULTU     6'h19
`define FN_DIV       6'h1a
`define FN_DIVU      6'h1b
`define FN_ADDU      6'h21
`define FN_SUBU      6'h23
`define FN_AND       6'h24
`define FN_OR        6'h25
`define FN_XOR       6'h26
`define FN_SLT       6'h2a
`define FN_SLTU      6'h2b

`endif

// File: mips_exec_pkg.sv
`include "mips_exec_params.svh"

package mips_exec_pkg;

	typedef enum logic [4:0] {
		ALU_AND    = 5'd0,
		ALU_OR     = 5'd1,
		ALU_XOR    = 5'd2,
		ALU_ADD    = 5'd3,
		ALU_SUB    = 5'd4,
		ALU_SLT    = 5'd5,	// Signed compare
		ALU_SLTU   = 5'd6,
		ALU_SLL    = 5'd7,
		ALU_SRL    = 5'd8,
		ALU_SRA    = 5'd9,
		ALU_LUI    = 5'd10,
		ALU_PASS_A = 5'd11,	// JR target out on y
		ALU_MFHI   = 5'd12,
		ALU_MFLO   = 5'd13,
		ALU_BEQ    = 5'd14,	// Branch ops return taken in bit 0
		ALU_BNE    = 5'd15,
		ALU_BLEZ   = 5'd16,
		ALU_BGTZ   = 5'd17
	} alu_op_t;

	typedef enum logic [2:0] {
		HILO_NONE  = 3'd0,
		HILO_MULT  = 3'd1,
		HILO_MULTU = 3'd2,
		HILO_DIV   = 3'd3,
		HILO_DIVU  = 3'd4
	} hilo_op_t;

	typedef struct packed {
		logic [5:0]              opcode;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_REG_AW-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} rtype_t;

	typedef struct packed {
		logic [5:0]              opcode;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [15:0]             imm;
	} itype_t;

	// One instruction word, two field layouts
	typedef union packed {
		rtype_t r;
		itype_t i;
	} instr_u;

endpackage

// File: mips_decoder.sv
`timescale 1ns/1ps
`include "mips_exec_params.svh"

module mips_decoder import mips_exec_pkg::*; (
	input  logic                    instr_valid,
	input  instr_u                  instr,
	input  logic [`MIPS_XLEN-1:0]   rs_val,
	input  logic [`MIPS_XLEN-1:0]   rt_val,
	output alu_op_t                 alu_op,
	output logic [`MIPS_XLEN-1:0]   a_val,
	output logic [`MIPS_XLEN-1:0]   b_val,
	output logic [4:0]              shamt,
	output hilo_op_t                hilo_op,
	output logic [`MIPS_REG_AW-1:0] dest_reg,
	output logic                    reg_write,
	output logic                    is_branch,
	output logic                    is_jump,
	output logic                    illegal
);

	logic [`MIPS_XLEN-1:0] imm_sext;
	logic [`MIPS_XLEN-1:0] imm_zext;
	logic                  shift_op;	// R-type shift, A comes from rt
	logic                  var_shift;	// Shift amount from rs
	hilo_op_t              hop;

	assign imm_sext = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
	assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, instr.i.imm};

	always_comb begin
		alu_op    = ALU_AND;
		b_val     = rt_val;
		hop       = HILO_NONE;
		dest_reg  = instr.i.rt;
		reg_write = 1'b1;
		is_branch = 1'b0;
		is_jump   = 1'b0;
		illegal   = 1'b0;
		shift_op  = 1'b0;
		var_shift = 1'b0;

		if (instr.r.opcode == `OP_RTYPE) begin
			dest_reg = instr.r.rd;
			case (instr.r.funct)
				`FN_SLL,
				`FN_SLLV: alu_op = ALU_SLL;
				`FN_SRL,
				`FN_SRLV: alu_op = ALU_SRL;
				`FN_SRA,
				`FN_SRAV: alu_op = ALU_SRA;
				`FN_JR: begin
					alu_op    = ALU_PASS_A;
					is_jump   = 1'b1;
					reg_write = 1'b0;
				end
				`FN_MFHI: alu_op = ALU_MFHI;
				`FN_MFLO: alu_op = ALU_MFLO;
				`FN_MULT:  hop = HILO_MULT;
				`FN_MULTU: hop = HILO_MULTU;
				`FN_DIV:   hop = HILO_DIV;
				`FN_DIVU:  hop = HILO_DIVU;
				`FN_ADDU: alu_op = ALU_ADD;
				`FN_SUBU: alu_op = ALU_SUB;
				`FN_AND:  alu_op = ALU_AND;
				`FN_OR:   alu_op = ALU_OR;
				`FN_XOR:  alu_op = ALU_XOR;
				`FN_SLT:  alu_op = ALU_SLT;
				`FN_SLTU: alu_op = ALU_SLTU;
				default:  illegal = 1'b1;
			endcase
			shift_op  = (instr.r.funct[5:3] == 3'b000) && !illegal;	// Funct 0x00..0x07
			var_shift = instr.r.funct[2];
			if (hop != HILO_NONE)
				reg_write = 1'b0;	// HI/LO only, no GPR write
		end else begin
			case (instr.i.opcode)
				`OP_ADDIU: begin
					alu_op = ALU_ADD;
					b_val  = imm_sext;
				end
				`OP_SLTI: begin
					alu_op = ALU_SLT;
					b_val  = imm_sext;
				end
				`OP_SLTIU: begin
					alu_op = ALU_SLTU;
					b_val  = imm_sext;	// Sign extended, then compared unsigned
				end
				`OP_ANDI: begin
					alu_op = ALU_AND;
					b_val  = imm_zext;
				end
				`OP_ORI: begin
					alu_op = ALU_OR;
					b_val  = imm_zext;
				end
				`OP_XORI: begin
					alu_op = ALU_XOR;
					b_val  = imm_zext;
				end
				`OP_LUI: begin
					alu_op = ALU_LUI;
					b_val  = imm_zext;	// Raw immediate, ALU moves it up
				end
				`OP_BEQ:  alu_op = ALU_BEQ;
				`OP_BNE:  alu_op = ALU_BNE;
				`OP_BLEZ: alu_op = ALU_BLEZ;
				`OP_BGTZ: alu_op = ALU_BGTZ;
				default:  illegal = 1'b1;
			endcase
			if (instr.i.opcode[5:2] == 4'b0001 && !illegal) begin
				is_branch = 1'b1;
				reg_write = 1'b0;
			end
		end

		if (illegal)
			reg_write = 1'b0;
	end

	assign a_val   = shift_op ? rt_val : rs_val;
	assign shamt   = var_shift ? rs_val[4:0] : instr.r.shamt;
	assign hilo_op = instr_valid ? hop : HILO_NONE;	// Idle cycles never touch HI/LO

endmodule

// File: mips_alu.sv
`timescale 1ns/1ps
`include "mips_exec_params.svh"

module mips_alu import mips_exec_pkg::*; (
	input  alu_op_t               alu_op,
	input  logic [`MIPS_XLEN-1:0] a_val,
	input  logic [`MIPS_XLEN-1:0] b_val,
	input  logic [4:0]            shamt,
	input  logic [`MIPS_XLEN-1:0] hi,
	input  logic [`MIPS_XLEN-1:0] lo,
	output logic [`MIPS_XLEN-1:0] y
);

	logic signed [`MIPS_XLEN-1:0] a_s;
	logic signed [`MIPS_XLEN-1:0] b_s;
	logic                         lt_s;
	logic                         lt_u;
	logic                         eq;
	logic                         a_neg;
	logic                         a_zero;
	logic                         cond;	// Compare or branch outcome

	assign a_s    = a_val;
	assign b_s    = b_val;
	assign lt_s   = a_s < b_s;
	assign lt_u   = a_val < b_val;
	assign eq     = a_val == b_val;
	assign a_neg  = a_val[`MIPS_XLEN-1];
	assign a_zero = a_val == '0;

	always_comb begin
		case (alu_op)
			ALU_SLT:  cond = lt_s;
			ALU_SLTU: cond = lt_u;
			ALU_BEQ:  cond = eq;
			ALU_BNE:  cond = !eq;
			ALU_BLEZ: cond = a_neg || a_zero;	// Signed a <= 0
			ALU_BGTZ: cond = !a_neg && !a_zero;
			default:  cond = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_AND:    y = a_val & b_val;
			ALU_OR:     y = a_val | b_val;
			ALU_XOR:    y = a_val ^ b_val;
			ALU_ADD:    y = a_val + b_val;
			ALU_SUB:    y = a_val - b_val;
			ALU_SLL:    y = a_val << shamt;
			ALU_SRL:    y = a_val >> shamt;
			ALU_SRA:    y = a_s >>> shamt;	// Sign bit fills from the left
			ALU_LUI:    y = {b_val[15:0], 16'h0000};
			ALU_PASS_A: y = a_val;
			ALU_MFHI:   y = hi;
			ALU_MFLO:   y = lo;
			ALU_SLT,
			ALU_SLTU,
			ALU_BEQ,
			ALU_BNE,
			ALU_BLEZ,
			ALU_BGTZ:   y = {{(`MIPS_XLEN-1){1'b0}}, cond};
			default:    y = '0;
		endcase
	end

endmodule

// File: mips_hilo_unit.sv
`timescale 1ns/1ps
`include "mips_exec_params.svh"

module mips_hilo_unit import mips_exec_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  hilo_op_t              hilo_op,
	input  logic [`MIPS_XLEN-1:0] rs_val,
	input  logic [`MIPS_XLEN-1:0] rt_val,
	output logic [`MIPS_XLEN-1:0] hi,
	output logic [`MIPS_XLEN-1:0] lo
);

	logic signed [2*`MIPS_XLEN-1:0] prod_s;
	logic        [2*`MIPS_XLEN-1:0] prod_u;
	logic        [`MIPS_XLEN-1:0]   dvd;	// Divider operands, magnitudes for DIV
	logic        [`MIPS_XLEN-1:0]   dvs;
	logic        [`MIPS_XLEN-1:0]   q_raw;
	logic        [`MIPS_XLEN-1:0]   r_raw;
	logic        [`MIPS_XLEN-1:0]   quot;
	logic        [`MIPS_XLEN-1:0]   rem;
	logic                           is_signed;
	logic                           q_neg;

	assign prod_s = $signed(rs_val) * $signed(rt_val);
	assign prod_u = rs_val * rt_val;

	// One unsigned divider serves both DIV and DIVU
	assign is_signed = hilo_op == HILO_DIV;
	assign dvd   = (is_signed && rs_val[`MIPS_XLEN-1]) ? -rs_val : rs_val;
	assign dvs   = (is_signed && rt_val[`MIPS_XLEN-1]) ? -rt_val : rt_val;
	assign q_raw = (dvs == '0) ? '0 : dvd / dvs;
	assign r_raw = (dvs == '0) ? '0 : dvd % dvs;
	assign q_neg = is_signed && (rs_val[`MIPS_XLEN-1] ^ rt_val[`MIPS_XLEN-1]);

	always_comb begin
		if (rt_val == '0) begin
			quot = '1;	// Divide by zero rule
			rem  = rs_val;
		end else begin
			quot = q_neg ? -q_raw : q_raw;	// Truncate toward zero
			rem  = (is_signed && rs_val[`MIPS_XLEN-1]) ? -r_raw : r_raw;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			case (hilo_op)
				HILO_MULT: begin
					hi <= prod_s[2*`MIPS_XLEN-1:`MIPS_XLEN];
					lo <= prod_s[`MIPS_XLEN-1:0];
				end
				HILO_MULTU: begin
					hi <= prod_u[2*`MIPS_XLEN-1:`MIPS_XLEN];
					lo <= prod_u[`MIPS_XLEN-1:0];
				end
				HILO_DIV,
				HILO_DIVU: begin
					hi <= rem;	// Remainder in HI, quotient in LO
					lo <= quot;
				end
				default: begin
					hi <= hi;
					lo <= lo;
				end
			endcase
		end
	end

endmodule

// File: mips_result_stage.sv
`timescale 1ns/1ps
`include "mips_exec_params.svh"

module mips_result_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    instr_valid,
	input  logic [`MIPS_XLEN-1:0]   y,
	input  logic [`MIPS_REG_AW-1:0] dest_reg,
	input  logic                    reg_write,
	input  logic                    is_branch,
	input  logic                    is_jump,
	input  logic                    illegal,
	output logic                    result_valid,
	output logic [`MIPS_XLEN-1:0]   result,
	output logic                    zero,
	output logic                    wb_en,
	output logic [`MIPS_REG_AW-1:0] wb_reg,
	output logic                    branch_taken,
	output logic                    jump_reg,
	output logic                    illegal_instr
);

	// Flags pulse for one cycle with result_valid
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid  <= 1'b0;
			zero          <= 1'b0;
			wb_en         <= 1'b0;
			branch_taken  <= 1'b0;
			jump_reg      <= 1'b0;
			illegal_instr <= 1'b0;
		end else begin
			result_valid  <= instr_valid;
			zero          <= instr_valid && (y == '0);
			wb_en         <= instr_valid && reg_write;
			branch_taken  <= instr_valid && is_branch && y[0];	// Taken bit from ALU
			jump_reg      <= instr_valid && is_jump;
			illegal_instr <= instr_valid && illegal;
		end
	end

	// Result and destination hold until the next strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
			wb_reg <= '0;
		end else if (instr_valid) begin
			result <= y;
			wb_reg <= dest_reg;
		end
	end

endmodule

// File: mips_exec_top.sv
`timescale 1ns/1ps
`include "mips_exec_params.svh"

module mips_exec_top import mips_exec_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    instr_valid,
	input  logic [`MIPS_XLEN-1:0]   instr,
	input  logic [`MIPS_XLEN-1:0]   rs_val,
	input  logic [`MIPS_XLEN-1:0]   rt_val,
	output logic                    result_valid,
	output logic [`MIPS_XLEN-1:0]   result,
	output logic                    zero,
	output logic                    wb_en,
	output logic [`MIPS_REG_AW-1:0] wb_reg,
	output logic                    branch_taken,
	output logic                    jump_reg,
	output logic                    illegal_instr
);

	alu_op_t                 alu_op;
	hilo_op_t                hilo_op;
	logic [`MIPS_XLEN-1:0]   a_val;
	logic [`MIPS_XLEN-1:0]   b_val;
	logic [4:0]              shamt;
	logic [`MIPS_XLEN-1:0]   y;
	logic [`MIPS_XLEN-1:0]   hi;
	logic [`MIPS_XLEN-1:0]   lo;
	logic [`MIPS_REG_AW-1:0] dest_reg;
	logic                    reg_write;
	logic                    is_branch;
	logic                    is_jump;
	logic                    illegal;

	mips_decoder u_decoder (
		.instr_valid (instr_valid),
		.instr       (instr),	// Raw word read as instr_u
		.rs_val      (rs_val),
		.rt_val      (rt_val),
		.alu_op      (alu_op),
		.a_val       (a_val),
		.b_val       (b_val),
		.shamt       (shamt),
		.hilo_op     (hilo_op),
		.dest_reg    (dest_reg),
		.reg_write   (reg_write),
		.is_branch   (is_branch),
		.is_jump     (is_jump),
		.illegal     (illegal)
	);

	mips_alu u_alu (
		.alu_op (alu_op),
		.a_val  (a_val),
		.b_val  (b_val),
		.shamt  (shamt),
		.hi     (hi),
		.lo     (lo),
		.y      (y)
	);

	mips_hilo_unit u_hilo (
		.clk     (clk),
		.arst_n  (arst_n),
		.hilo_op (hilo_op),
		.rs_val  (rs_val),
		.rt_val  (rt_val),
		.hi      (hi),
		.lo      (lo)
	);

	mips_result_stage u_result (
		.clk           (clk),
		.arst_n        (arst_n),
		.instr_valid   (instr_valid),
		.y             (y),
		.dest_reg      (dest_reg),
		.reg_write     (reg_write),
		.is_branch     (is_branch),
		.is_jump       (is_jump),
		.illegal       (illegal),
		.result_valid  (result_valid),
		.result        (result),
		.zero          (zero),
		.wb_en         (wb_en),
		.wb_reg        (wb_reg),
		.branch_taken  (branch_taken),
		.jump_reg      (jump_reg),
		.illegal_instr (illegal_instr)
	);

endmodule

// File: mips_exec_tb.sv
`timescale 1ns/1ps
`include "mips_exec_params.svh"

module mips_exec_tb import mips_exec_pkg::*; ();

	localparam int NUM_INSTR  = 3000;
	localparam int MAX_CYCLES = 6000;

	// Legal funct and opcode tables of six-bit entries
	localparam logic [119:0] FN_LIST = {`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV,
		`FN_SRAV, `FN_JR, `FN_MFHI, `FN_MFLO, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU,
		`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLTU};
	localparam logic [65:0] OP_LIST = {`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
		`OP_XORI, `OP_LUI, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ};

	typedef struct packed {
		logic        chk_res;	// Result and zero are defined
		logic [31:0] result;
		logic        wb_en;
		logic [4:0]  wb_reg;
		logic        taken;
		logic        jump;
		logic        illegal;
	} expect_t;

	logic        clk;
	logic        arst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic        result_valid;
	logic [31:0] result;
	logic        zero;
	logic        wb_en;
	logic [4:0]  wb_reg;
	logic        branch_taken;
	logic        jump_reg;
	logic        illegal_instr;

	logic [31:0] hi_m;	// Model HI/LO
	logic [31:0] lo_m;
	expect_t     exp_q[$];
	instr_u      w;
	expect_t     e;
	int          sent;
	int          cycles;

	mips_exec_top uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.rs_val        (rs_val),
		.rt_val        (rt_val),
		.result_valid  (result_valid),
		.result        (result),
		.zero          (zero),
		.wb_en         (wb_en),
		.wb_reg        (wb_reg),
		.branch_taken  (branch_taken),
		.jump_reg      (jump_reg),
		.illegal_instr (illegal_instr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic fail_with(input string msg);
		$display("Error: %s", msg);
		abort_run();
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic listed(input logic [5:0] code, input logic [119:0] list,
			input int n);
		for (int k = 0; k < n; k++) begin
			if (list[k*6 +: 6] == code)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic [31:0] pick_operand();
		if ($urandom % 8 != 0)
			return $urandom;
		case ($urandom % 4)
			0:       return 32'h0000_0000;
			1:       return 32'h0000_0001;
			2:       return 32'hffff_ffff;
			default: return 32'h8000_0000;
		endcase
	endfunction

	task automatic make_instr(output instr_u word);
		word = $urandom;
		if ($urandom % 16 == 0) begin	// Illegal word
			if ($urandom % 2) begin
				word.r.opcode = `OP_RTYPE;
				do begin
					word.r.funct = $urandom % 64;
				end while (listed(word.r.funct, FN_LIST, 20));
			end else begin
				do begin
					word.i.opcode = $urandom % 64;
				end while (word.i.opcode == `OP_RTYPE || listed(word.i.opcode, OP_LIST, 11));
			end
		end else if ($urandom % 2) begin
			word.r.opcode = `OP_RTYPE;
			word.r.funct  = FN_LIST[($urandom % 20) * 6 +: 6];
		end else begin
			word.i.opcode = OP_LIST[($urandom % 11) * 6 +: 6];
		end
	endtask

	task automatic divide_signed(input logic [31:0] rs, input logic [31:0] rt);
		logic signed [31:0] a;
		logic signed [31:0] b;
		a = rs;
		b = rt;
		if (rt == 32'h0) begin
			hi_m = rs;
			lo_m = 32'hffff_ffff;
		end else if (rs == 32'h8000_0000 && rt == 32'hffff_ffff) begin
			hi_m = 32'h0;	// Quotient wraps to itself
			lo_m = 32'h8000_0000;
		end else begin
			hi_m = a % b;
			lo_m = a / b;
		end
	endtask

	task automatic predict(input instr_u word, input logic [31:0] rs, input logic [31:0] rt,
			output expect_t ex);
		logic [31:0] imm_s;
		logic [31:0] imm_z;
		logic [63:0] prod;
		logic        no_wb;
		imm_s = {{16{word.i.imm[15]}}, word.i.imm};
		imm_z = {16'h0000, word.i.imm};
		ex    = '0;
		no_wb = 1'b0;
		ex.wb_en   = 1'b1;
		ex.chk_res = 1'b1;
		ex.wb_reg  = (word.r.opcode == `OP_RTYPE) ? word.r.rd : word.i.rt;
		if (word.r.opcode == `OP_RTYPE) begin
			case (word.r.funct)
				`FN_SLL:  ex.result = rt << word.r.shamt;
				`FN_SRL:  ex.result = rt >> word.r.shamt;
				`FN_SRA:  ex.result = $signed(rt) >>> word.r.shamt;
				`FN_SLLV: ex.result = rt << rs[4:0];
				`FN_SRLV: ex.result = rt >> rs[4:0];
				`FN_SRAV: ex.result = $signed(rt) >>> rs[4:0];
				`FN_JR: begin
					ex.result = rs;
					ex.jump   = 1'b1;
					ex.wb_en  = 1'b0;
				end
				`FN_MFHI: ex.result = hi_m;
				`FN_MFLO: ex.result = lo_m;
				`FN_MULT: begin
					prod  = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
					{hi_m, lo_m} = prod;
					no_wb = 1'b1;
				end
				`FN_MULTU: begin
					prod  = {32'h0, rs} * {32'h0, rt};
					{hi_m, lo_m} = prod;
					no_wb = 1'b1;
				end
				`FN_DIV: begin
					divide_signed(rs, rt);
					no_wb = 1'b1;
				end
				`FN_DIVU: begin
					hi_m  = (rt == 32'h0) ? rs : rs % rt;
					lo_m  = (rt == 32'h0) ? 32'hffff_ffff : rs / rt;
					no_wb = 1'b1;
				end
				`FN_ADDU: ex.result = rs + rt;
				`FN_SUBU: ex.result = rs - rt;
				`FN_AND:  ex.result = rs & rt;
				`FN_OR:   ex.result = rs | rt;
				`FN_XOR:  ex.result = rs ^ rt;
				`FN_SLT:  ex.result = {31'h0, $signed(rs) < $signed(rt)};
				`FN_SLTU: ex.result = {31'h0, rs < rt};
				default: begin
					ex.illegal = 1'b1;
					no_wb      = 1'b1;
				end
			endcase
		end else begin
			case (word.i.opcode)
				`OP_ADDIU: ex.result = rs + imm_s;
				`OP_SLTI:  ex.result = {31'h0, $signed(rs) < $signed(imm_s)};
				`OP_SLTIU: ex.result = {31'h0, rs < imm_s};
				`OP_ANDI:  ex.result = rs & imm_z;
				`OP_ORI:   ex.result = rs | imm_z;
				`OP_XORI:  ex.result = rs ^ imm_z;
				`OP_LUI:   ex.result = {word.i.imm, 16'h0000};
				`OP_BEQ:   ex.taken  = (rs == rt);
				`OP_BNE:   ex.taken  = (rs != rt);
				`OP_BLEZ:  ex.taken  = ($signed(rs) <= 0);
				`OP_BGTZ:  ex.taken  = ($signed(rs) > 0);
				default:   ex.illegal = 1'b1;
			endcase
			if (ex.illegal || word.i.opcode == `OP_BEQ || word.i.opcode == `OP_BNE
					|| word.i.opcode == `OP_BLEZ || word.i.opcode == `OP_BGTZ)
				no_wb = 1'b1;	// Branches and illegal words write nothing
		end
		if (no_wb) begin
			ex.wb_en   = 1'b0;
			ex.chk_res = 1'b0;
		end
	endtask

	task automatic compare_outputs();
		expect_t ex;
		if (exp_q.size() == 0) begin
			if (result_valid)
				fail_with("result_valid went high in a cycle that followed no strobe");
			check("wb_en", wb_en, 0);
			check("zero", zero, 0);
			check("branch_taken", branch_taken, 0);
			check("jump_reg", jump_reg, 0);
			check("illegal_instr", illegal_instr, 0);
		end else begin
			ex = exp_q.pop_front();
			if (!result_valid)
				fail_with("result_valid did not rise one cycle after a strobe");
			check("wb_en", wb_en, ex.wb_en);
			check("branch_taken", branch_taken, ex.taken);
			check("jump_reg", jump_reg, ex.jump);
			check("illegal_instr", illegal_instr, ex.illegal);
			if (ex.wb_en)
				check("wb_reg", wb_reg, ex.wb_reg);
			if (ex.chk_res) begin
				check("result", result, ex.result);
				check("zero", zero, ex.result == 32'h0);
			end
		end
	endtask

	initial begin
		void'($urandom(59229));
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		rs_val      = '0;
		rt_val      = '0;
		hi_m        = '0;
		lo_m        = '0;
		for (int k = 0; k < 8; k++)
			@(posedge clk);
		#1 arst_n = 1'b1;
		check("result_valid", result_valid, 0);
		check("result", result, 0);

		sent   = 0;
		cycles = 0;
		while (sent < NUM_INSTR && cycles < MAX_CYCLES) begin
			@(posedge clk);
			#1;
			compare_outputs();
			make_instr(w);
			rs_val = pick_operand();
			rt_val = pick_operand();
			if (w.r.opcode == `OP_RTYPE && (w.r.funct == `FN_DIV || w.r.funct == `FN_DIVU)
					&& $urandom % 12 == 0)
				rt_val = 32'h0;	// Divide by zero case
			instr       = w;
			instr_valid = ($urandom % 5 != 0);
			if (instr_valid) begin
				predict(w, rs_val, rt_val, e);
				exp_q.push_back(e);
				sent++;
			end
			cycles++;
		end

		cycles = 0;
		while (exp_q.size() != 0 && cycles < 4) begin	// Drain the last result
			@(posedge clk);
			#1;
			compare_outputs();
			instr_valid = 1'b0;
			cycles++;
		end

		if (sent < NUM_INSTR || exp_q.size() != 0) begin
			fail_with("run timed out before every instruction was issued and checked");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: mips_exec.f
+incdir+.
mips_exec_pkg.sv
mips_decoder.sv
mips_alu.sv
mips_hilo_unit.sv
mips_result_stage.sv
mips_exec_top.sv
mips_exec_tb.sv
